// ==== hdl/cpu_types_pkg.sv ====
/*
 shared types for the three-stage core
 word and register select types, opcode and funct encodings,
 and the payload carried by the EX/WB latch
*/

package cpu_types_pkg;

   //////////////////////////////////////////////////////////////////////
   // basic widths
   //////////////////////////////////////////////////////////////////////
   localparam int WORD_W = 32;
   localparam int REG_W  = 5;

   typedef logic [WORD_W-1:0] word_t;   // data and instruction word
   typedef logic [REG_W-1:0]  regbits_t; // register select

   //////////////////////////////////////////////////////////////////////
   // instruction encodings
   //////////////////////////////////////////////////////////////////////
   // major opcode, bits 31:26
   typedef enum logic [5:0] {
      RTYPE = 6'b000000,
      ADDIU = 6'b001001,
      ORI   = 6'b001101,
      LUI   = 6'b001111,
      HALT  = 6'b111111 // all ones
   } opcode_t;

   // r-type funct field, bits 5:0
   typedef enum logic [5:0] {
      SLL  = 6'b000000,
      ADDU = 6'b100001,
      SUBU = 6'b100011,
      AND  = 6'b100100,
      OR   = 6'b100101
   } funct_t;

   // what writeback needs, nothing more
   typedef struct packed {
      logic     wen; // register file write
      regbits_t sel; // destination
      word_t    dat; // alu result
   } wb_t;

endpackage

// ==== hdl/pipeline_reg.sv ====
/*
 inter-stage latch for any payload type
 loads with valid on enable, clears to a zero bubble on flush
*/

`timescale 1ns/1ps

module pipeline_reg #(
   parameter type payload_t = logic [31:0]
) (
   input  logic     CLK,
   input  logic     rst,
   input  logic     en,    // take din this edge
   input  logic     flush, // drop contents, load a bubble
   input  payload_t din,
   output logic     valid,
   output payload_t dout
);

   always_ff @(posedge CLK) begin
      if (rst || flush) begin
         valid <= 1'b0;
         dout  <= '0; // all-zero bubble
      end else if (en) begin
         valid <= 1'b1;
         dout  <= din;
      end
      // otherwise hold
   end

endmodule

// ==== hdl/register_file.sv ====
/*
 32 x 32 register file
 two combinational reads, one write at the clock edge,
 register 0 reads as zero and drops writes
*/

`timescale 1ns/1ps

module register_file (
   input  logic                    CLK,
   input  logic                    rst,
   input  logic                    wen,
   input  cpu_types_pkg::regbits_t wsel,
   input  cpu_types_pkg::word_t    wdat,
   input  cpu_types_pkg::regbits_t rsel1,
   input  cpu_types_pkg::regbits_t rsel2,
   output cpu_types_pkg::word_t    rdat1,
   output cpu_types_pkg::word_t    rdat2
);
   import cpu_types_pkg::*;

   word_t regs [32]; // entry 0 never written

   // write port
   always_ff @(posedge CLK) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && (wsel != '0)) begin
         regs[wsel] <= wdat;
      end
   end

   // read ports, no internal bypass
   // same-cycle writes are covered by forwarding in execute
   assign rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
   assign rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];

endmodule

// ==== hdl/fetch_unit.sv ====
/*
 fetch stage
 owns the program counter and the instruction memory request,
 hands each accepted word to the IF/ID latch
*/

`timescale 1ns/1ps

module fetch_unit #(
   parameter cpu_types_pkg::word_t PC_INIT = '0
) (
   input  logic                 CLK,
   input  logic                 rst,
   input  logic                 halt,     // from execute, sticky
   input  logic                 ihit,     // word on imemload is valid
   input  cpu_types_pkg::word_t imemload,
   output logic                 imemREN,
   output cpu_types_pkg::word_t imemaddr,
   output logic                 fd_en,    // load IF/ID this edge
   output cpu_types_pkg::word_t fd_instr
);
   import cpu_types_pkg::*;

   word_t pc;     // address of the word being requested
   logic  accept; // request and hit in the same cycle

   //////////////////////////////////////////////////////////////////////
   // request side
   //////////////////////////////////////////////////////////////////////
   assign imemREN  = ~halt; // stop asking once halted
   assign imemaddr = pc;
   assign accept   = imemREN & ihit;

   // program counter
   // holds on a miss, so the same address is asked again
   always_ff @(posedge CLK) begin
      if (rst) begin
         pc <= PC_INIT;
      end else if (accept) begin
         pc <= pc + 32'd4; // next sequential word
      end
   end

   //////////////////////////////////////////////////////////////////////
   // into IF/ID
   //////////////////////////////////////////////////////////////////////
   // no hit means a bubble goes down the pipe
   assign fd_en    = accept;
   assign fd_instr = imemload; // only meaningful with fd_en

endmodule

// ==== hdl/execute_unit.sv ====
/*
 decode/execute stage
 decodes the IF/ID word, reads registers, forwards from EX/WB,
 runs the alu, loads the EX/WB latch and tracks halt
*/

`timescale 1ns/1ps

module execute_unit (
   input  logic                    CLK,
   input  logic                    rst,
   input  logic                    fd_valid,  // IF/ID holds a real word
   input  cpu_types_pkg::word_t    fd_instr,
   output logic                    halt,
   output logic                    wb_en,     // register write this cycle
   output cpu_types_pkg::regbits_t wb_sel,
   output cpu_types_pkg::word_t    wb_dat
);
   import cpu_types_pkg::*;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_PASSB
   } alu_op_t;

   // instruction fields
   opcode_t    opcode;
   funct_t     funct;
   regbits_t   rs, rt, rd;
   logic [4:0] shamt;
   logic [15:0] imm16;

   // control
   alu_op_t  alu_op;
   logic     use_imm; // op2 from extender
   logic     writes;  // instruction produces a register value
   regbits_t dest;
   logic     issue;   // word is live and not squashed
   logic     halted;

   // datapath
   word_t imm_ext;
   word_t rdat1, rdat2;
   logic  fwd_rs, fwd_rt;
   word_t rs_val, rt_val;
   word_t op1, op2, alu_res;

   // EX/WB
   wb_t  ex_d, ex_q;
   logic wb_valid;

   //////////////////////////////////////////////////////////////////////
   // decode
   //////////////////////////////////////////////////////////////////////
   assign opcode = opcode_t'(fd_instr[31:26]);
   assign rs     = fd_instr[25:21];
   assign rt     = fd_instr[20:16];
   assign rd     = fd_instr[15:11];
   assign shamt  = fd_instr[10:6];
   assign funct  = funct_t'(fd_instr[5:0]);
   assign imm16  = fd_instr[15:0];

   assign issue = fd_valid & ~halted; // squash everything after halt

   always_comb begin
      alu_op  = ALU_ADD;
      use_imm = 1'b1;
      writes  = 1'b1;
      dest    = rt; // i-type default
      case (opcode)
         RTYPE: begin
            use_imm = 1'b0;
            dest    = rd;
            case (funct)
               ADDU:    alu_op = ALU_ADD;
               SUBU:    alu_op = ALU_SUB;
               AND:     alu_op = ALU_AND;
               OR:      alu_op = ALU_OR;
               SLL:     alu_op = ALU_SLL;
               default: writes = 1'b0; // unsupported funct, no effect
            endcase
         end
         ADDIU:   alu_op = ALU_ADD;
         ORI:     alu_op = ALU_OR;
         LUI:     alu_op = ALU_PASSB; // rs ignored
         default: writes = 1'b0;      // HALT writes nothing
      endcase
   end

   // extender
   always_comb begin
      case (opcode)
         ADDIU:   imm_ext = {{16{imm16[15]}}, imm16}; // sign extend
         LUI:     imm_ext = {imm16, 16'h0000};        // upper half
         default: imm_ext = {16'h0000, imm16};        // ori, zero extend
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // operands, forwarded from writeback
   //////////////////////////////////////////////////////////////////////
   register_file rf (
      .CLK   (CLK),
      .rst   (rst),
      .wen   (wb_en),
      .wsel  (wb_sel),
      .wdat  (wb_dat),
      .rsel1 (rs),
      .rsel2 (rt),
      .rdat1 (rdat1),
      .rdat2 (rdat2)
   );

   assign fwd_rs = wb_en && (wb_sel == rs) && (rs != '0);
   assign fwd_rt = wb_en && (wb_sel == rt) && (rt != '0);
   assign rs_val = fwd_rs ? wb_dat : rdat1;
   assign rt_val = fwd_rt ? wb_dat : rdat2;

   assign op1 = rs_val;
   assign op2 = use_imm ? imm_ext : rt_val; // alu source mux

   // alu
   always_comb begin
      case (alu_op)
         ALU_ADD:   alu_res = op1 + op2;
         ALU_SUB:   alu_res = op1 - op2;
         ALU_AND:   alu_res = op1 & op2;
         ALU_OR:    alu_res = op1 | op2;
         ALU_SLL:   alu_res = op2 << shamt; // shifts rt
         default:   alu_res = op2;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // EX/WB latch and halt
   //////////////////////////////////////////////////////////////////////
   assign ex_d.wen = writes & (dest != '0); // r0 writes dropped here
   assign ex_d.sel = dest;
   assign ex_d.dat = alu_res;

   pipeline_reg #(.payload_t(wb_t)) ex_wb (
      .CLK   (CLK),
      .rst   (rst),
      .en    (1'b1),
      .flush (~issue), // bubble for empty or squashed slots
      .din   (ex_d),
      .valid (wb_valid),
      .dout  (ex_q)
   );

   assign wb_en  = wb_valid & ex_q.wen;
   assign wb_sel = ex_q.sel;
   assign wb_dat = ex_q.dat;

   // sticky until reset
   always_ff @(posedge CLK) begin
      if (rst) begin
         halted <= 1'b0;
      end else if (issue && (opcode == HALT)) begin
         halted <= 1'b1;
      end
   end

   assign halt = halted;

endmodule

// ==== hdl/datapath.sv ====
/*
 core top level
 fetch, IF/ID latch and execute on the cache-side instruction port
*/

`timescale 1ns/1ps

module datapath #(
   parameter cpu_types_pkg::word_t PC_INIT = '0
) (
   input  logic                    CLK,
   input  logic                    rst,
   input  logic                    ihit,
   input  cpu_types_pkg::word_t    imemload,
   output logic                    imemREN,
   output cpu_types_pkg::word_t    imemaddr,
   output logic                    wb_en,
   output cpu_types_pkg::regbits_t wb_sel,
   output cpu_types_pkg::word_t    wb_dat,
   output logic                    halt
);
   import cpu_types_pkg::*;

   logic  fd_en;     // fetch accepted a word
   word_t fd_instr;  // word into IF/ID
   logic  fd_valid;  // IF/ID not a bubble
   word_t fd_q;      // word out of IF/ID

   //////////////////////////////////////////////////////////////////////
   // fetch -> IF/ID -> execute
   //////////////////////////////////////////////////////////////////////
   fetch_unit #(.PC_INIT(PC_INIT)) fetch (
      .CLK      (CLK),
      .rst      (rst),
      .halt     (halt),
      .ihit     (ihit),
      .imemload (imemload),
      .imemREN  (imemREN),
      .imemaddr (imemaddr),
      .fd_en    (fd_en),
      .fd_instr (fd_instr)
   );

   // a miss loads a bubble rather than holding the old word
   pipeline_reg #(.payload_t(word_t)) if_id (
      .CLK   (CLK),
      .rst   (rst),
      .en    (fd_en),
      .flush (~fd_en),
      .din   (fd_instr),
      .valid (fd_valid),
      .dout  (fd_q)
   );

   execute_unit exec (
      .CLK      (CLK),
      .rst      (rst),
      .fd_valid (fd_valid),
      .fd_instr (fd_q),
      .halt     (halt),
      .wb_en    (wb_en),
      .wb_sel   (wb_sel),
      .wb_dat   (wb_dat)
   );

endmodule

// ==== bench/datapath_tb.sv ====
/*
 testbench for the three-stage core
 loads program and expected writes from the trace, models the
 instruction memory with random ihit gaps and checks every writeback
*/

`timescale 1ns/1ps

module datapath_tb;
   import cpu_types_pkg::*;

   localparam word_t PC_BASE     = 32'h0000_0100; // program load address
   localparam int    MEM_WORDS   = 64;
   localparam int    MAX_WRITES  = 64;
   localparam int    RUN_LIMIT   = 500; // cycles allowed until halt
   localparam int    HALT_CYCLES = 20;  // quiet cycles after halt

   logic     CLK;
   logic     rst;
   logic     ihit;
   word_t    imemload;
   logic     imemREN;
   word_t    imemaddr;
   logic     wb_en;
   regbits_t wb_sel;
   word_t    wb_dat;
   logic     halt;

   word_t  mem [MEM_WORDS];      // program image from PC_BASE up
   word_t  exp_reg [MAX_WRITES]; // expected writes in program order
   word_t  exp_dat [MAX_WRITES];
   int     nwords;
   int     nexp;
   int     nseen;                // writes observed so far
   integer seed;

   datapath #(.PC_INIT(PC_BASE)) datapath_i (
      .CLK      (CLK),
      .rst      (rst),
      .ihit     (ihit),
      .imemload (imemload),
      .imemREN  (imemREN),
      .imemaddr (imemaddr),
      .wb_en    (wb_en),
      .wb_sel   (wb_sel),
      .wb_dat   (wb_dat),
      .halt     (halt)
   );

   initial begin
      CLK = 1'b0;
      forever #50 CLK = ~CLK; // 100 ns period
   end

   //////////////////////////////////////////////////////////////////////
   // reporting
   //////////////////////////////////////////////////////////////////////
   task automatic check(input word_t actual, input word_t expected, input string what);
      if (actual !== expected) begin
         $display("Fail at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
         $display("Result: FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic abort_run(input string why);
      $display("Error at %0d ns: %s", $time, why);
      $display("Result: FAILED");
      $fatal(1, "run aborted");
   endtask

   //////////////////////////////////////////////////////////////////////
   // trace reader
   //////////////////////////////////////////////////////////////////////
   task automatic skip_line(input int fd);
      int c;
      c = $fgetc(fd);
      while (c != 10 && c != -1) begin // up to newline or eof
         c = $fgetc(fd);
      end
   endtask

   task automatic read_trace();
      int    fd;
      int    n;
      int    r;
      string tag;
      word_t v;
      bit    done;
      fd = $fopen("bench/datapath_trace.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open bench/datapath_trace.txt");
      end
      nwords = 0;
      nexp   = 0;
      done   = 1'b0;
      while (!done) begin
         n = $fscanf(fd, "%s", tag);
         if (n != 1) begin
            abort_run("trace ends without its E marker");
         end
         if (tag == "#") begin
            skip_line(fd); // comment line
         end else if (tag == "I") begin
            n = $fscanf(fd, "%h", v);
            if (n != 1 || nwords >= MEM_WORDS) begin
               abort_run("bad program line in trace");
            end
            mem[nwords] = v;
            nwords++;
            skip_line(fd); // trailing mnemonic
         end else if (tag == "W") begin
            n = $fscanf(fd, "%d %h", r, v);
            if (n != 2 || nexp >= MAX_WRITES) begin
               abort_run("bad write line in trace");
            end
            exp_reg[nexp] = word_t'(r);
            exp_dat[nexp] = v;
            nexp++;
            skip_line(fd);
         end else if (tag == "E") begin
            done = 1'b1;
         end else begin
            abort_run("unknown line tag in trace");
         end
      end
      $fclose(fd);
      if (nwords == 0 || nexp == 0) begin
         abort_run("trace holds no program or no expected writes");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // memory model and writeback monitor
   //////////////////////////////////////////////////////////////////////
   // called 1 ns after the edge when pc has settled
   task automatic drive_imem();
      word_t off;
      int    idx;
      ihit = ($unsigned($random(seed)) % 10) < 7; // about 70 percent hits
      if (imemREN) begin
         check({30'd0, imemaddr[1:0]}, 32'd0, "imemaddr alignment");
         off = (imemaddr - PC_BASE) >> 2; // below base wraps high
         if (off >= nwords) begin
            abort_run("core fetched outside the loaded program");
         end
         idx = int'(off);
         imemload = mem[idx];
      end else begin
         imemload = '0;
      end
   endtask

   task automatic observe_write();
      if (wb_en) begin
         if (nseen >= nexp) begin
            abort_run("register write seen after the last expected one");
         end
         check({27'd0, wb_sel}, exp_reg[nseen], $sformatf("write %0d register", nseen));
         check(wb_dat, exp_dat[nseen], $sformatf("write %0d data", nseen));
         nseen++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////
   initial begin
      int cycles;
      seed     = 32'hf933_a0cc;
      rst      = 1'b1;
      ihit     = 1'b0;
      imemload = '0;
      nseen    = 0;
      read_trace();

      repeat (4) @(posedge CLK);
      #1 rst = 1'b0;

      // state straight out of reset before any hit
      check({31'd0, imemREN}, 32'd1, "imemREN after reset");
      check(imemaddr, PC_BASE, "imemaddr after reset");
      check({31'd0, wb_en}, 32'd0, "wb_en after reset");
      check({31'd0, halt}, 32'd0, "halt after reset");

      // run until halt and check every write in order
      cycles = 0;
      while (!halt) begin
         drive_imem();
         @(posedge CLK);
         #1;
         observe_write();
         cycles++;
         if (cycles > RUN_LIMIT) begin
            abort_run($sformatf("halt never went high within %0d cycles", RUN_LIMIT));
         end
      end
      check(nseen, nexp, "write count at halt");

      // halted core stays quiet
      for (int i = 0; i < HALT_CYCLES; i++) begin
         drive_imem();
         @(posedge CLK);
         #1;
         check({31'd0, imemREN}, 32'd0, "imemREN while halted");
         check({31'd0, wb_en}, 32'd0, "wb_en while halted");
         check({31'd0, halt}, 32'd1, "halt held");
      end

      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== cpu.f ====
hdl/cpu_types_pkg.sv
hdl/pipeline_reg.sv
hdl/register_file.sv
hdl/fetch_unit.sv
hdl/execute_unit.sv
hdl/datapath.sv
bench/datapath_tb.sv

// ==== Makefile ====
# Verilator build for the three-stage core

VERILATOR  ?= verilator
TOP        := datapath_tb
FILELIST   := cpu.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

# parse and elaborate the whole tree under the testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# build and run, the exit status carries pass or fail
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/datapath_trace.txt ====
# columns: I <instruction hex> <mnemonic> is a program word, stored upward from PC_INIT
# W <register> <value hex> <note> is an expected write in program order, E ends the trace
I 24010005  addiu r1, r0, 5
I 2402fffd  addiu r2, r0, -3
I 00221821  addu  r3, r1, r2
I 00612023  subu  r4, r3, r1
I 34058f0f  ori   r5, r0, 0x8f0f
I 3c061234  lui   r6, 0x1234
I 00c53825  or    r7, r6, r5
I 00e44024  and   r8, r7, r4
I 00084900  sll   r9, r8, 4
I 24200007  addiu r0, r1, 7     no write
I 00095021  addu  r10, r0, r9   r0 reads zero
I 254affff  addiu r10, r10, -1
I 000a5823  subu  r11, r0, r10
I fc000000  halt
I 240c0001  addiu r12, r0, 1    squashed
I 240d0002  addiu r13, r0, 2    never fetched
W 1  00000005
W 2  fffffffd  sign extended
W 3  00000002  forwarded r2
W 4  fffffffd
W 5  00008f0f  zero extended
W 6  12340000  upper half
W 7  12348f0f
W 8  12348f0d
W 9  2348f0d0
W 10 2348f0d0
W 10 2348f0cf
W 11 dcb70f31
E
